// File: sdp_types_pkg.sv
package sdp_types_pkg;

    // lane geometry
    localparam int SIMD_DEGREE = 4;
    localparam int DWIDTH      = 16;
    localparam int PHIT_SIZE   = SIMD_DEGREE * DWIDTH;

    // per-stage table
    localparam int RF_DEPTH = 8;
    localparam int RF_AW    = 3;

    // iteration tag carried with every phit
    localparam int ITR_W = 8;

    typedef logic [DWIDTH-1:0]      lane_t;
    typedef logic [PHIT_SIZE-1:0]   phit_t;
    typedef logic [SIMD_DEGREE-1:0] lane_mask_t;
    typedef logic [ITR_W-1:0]       itr_t;
    typedef logic [RF_AW-1:0]       rf_addr_t;

    // lane i sits at data[i*DWIDTH +: DWIDTH]
    // phit is valid when any mask bit is set
    typedef struct packed {
        lane_mask_t mask;
        itr_t       itr;
        phit_t      data;
    } stage_bus_t;

endpackage

// File: sdp_cfg_pkg.sv
package sdp_cfg_pkg;

    import sdp_types_pkg::*;

    localparam int NUM_STAGES = 3;
    // cycles from stage input to stage output
    localparam int PE_LATENCY = 2;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_MAX,
        OP_MIN
    } pe_op_e;

    // operand sources
    typedef enum logic [1:0] {
        SRC_STREAM,
        SRC_ITR,
        SRC_IMM,
        SRC_RF
    } src_e;

    typedef logic [1:0] stage_idx_t;

    typedef struct packed {
        pe_op_e   op;
        src_e     src_a;
        src_e     src_b;
        lane_t    imm;
        rf_addr_t rd_addr;
        // table read address taken from the itr tag
        logic     use_itr;
        logic     wb_en;
        rf_addr_t wb_addr;
    } stage_cfg_t;

    // stream + 0, no write-back
    localparam stage_cfg_t CFG_RESET = '{
        op:      OP_ADD,
        src_a:   SRC_STREAM,
        src_b:   SRC_IMM,
        imm:     '0,
        rd_addr: '0,
        use_itr: 1'b0,
        wb_en:   1'b0,
        wb_addr: '0
    };

endpackage

// File: sdp_operand_sel.sv
`timescale 1ns/1ps

module sdp_operand_sel (
    input  sdp_types_pkg::stage_bus_t i_bus,
    input  sdp_cfg_pkg::stage_cfg_t   i_cfg,
    input  sdp_types_pkg::phit_t      i_rf_rdata,
    output sdp_types_pkg::rf_addr_t   o_rf_raddr,
    output sdp_types_pkg::phit_t      o_op_a,
    output sdp_types_pkg::phit_t      o_op_b
);

    import sdp_types_pkg::*;
    import sdp_cfg_pkg::*;

    phit_t itr_bcast;
    phit_t imm_bcast;

    // one 4:1 phit mux, used for both operands
    function automatic phit_t pick_src(
        input src_e  sel,
        input phit_t stream,
        input phit_t itr_b,
        input phit_t imm_b,
        input phit_t rf
    );
        phit_t res;
        case (sel)
            SRC_STREAM: res = stream;
            SRC_ITR:    res = itr_b;
            SRC_IMM:    res = imm_b;
            default:    res = rf;
        endcase
        return res;
    endfunction

    // tag and immediate are the same on every lane
    assign itr_bcast = {SIMD_DEGREE{lane_t'(i_bus.itr)}};
    assign imm_bcast = {SIMD_DEGREE{i_cfg.imm}};

    assign o_rf_raddr = i_cfg.use_itr ? i_bus.itr[RF_AW-1:0] : i_cfg.rd_addr;

    assign o_op_a = pick_src(i_cfg.src_a, i_bus.data, itr_bcast, imm_bcast, i_rf_rdata);
    assign o_op_b = pick_src(i_cfg.src_b, i_bus.data, itr_bcast, imm_bcast, i_rf_rdata);

endmodule

// File: sdp_pe_stage.sv
`timescale 1ns/1ps

module sdp_pe_stage (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  sdp_cfg_pkg::pe_op_e       i_op,
    input  sdp_types_pkg::lane_mask_t i_mask,
    input  sdp_types_pkg::itr_t       i_itr,
    input  sdp_types_pkg::phit_t      i_op_a,
    input  sdp_types_pkg::phit_t      i_op_b,
    output sdp_types_pkg::stage_bus_t o_bus
);

    import sdp_types_pkg::*;
    import sdp_cfg_pkg::*;

    phit_t      alu_res;
    lane_mask_t mask_pipe [PE_LATENCY];
    itr_t       itr_pipe  [PE_LATENCY];
    phit_t      data_pipe [PE_LATENCY];

    // unsigned lane ALU, add and sub wrap modulo 2^DWIDTH
    function automatic lane_t lane_alu(input pe_op_e op, input lane_t a, input lane_t b);
        lane_t res;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_MAX:  res = (a > b) ? a : b;
            default: res = (a < b) ? a : b;
        endcase
        return res;
    endfunction

    for (genvar i = 0; i < SIMD_DEGREE; i++) begin : g_lane
        assign alu_res[i*DWIDTH +: DWIDTH] = lane_alu(i_op,
                                                      i_op_a[i*DWIDTH +: DWIDTH],
                                                      i_op_b[i*DWIDTH +: DWIDTH]);
    end

    // valid mask pipeline
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < PE_LATENCY; s++) begin
                mask_pipe[s] <= '0;
            end
        end else begin
            mask_pipe[0] <= i_mask;
            for (int s = 1; s < PE_LATENCY; s++) begin
                mask_pipe[s] <= mask_pipe[s-1];
            end
        end
    end

    // result and tag follow the mask
    always_ff @(posedge clk) begin
        data_pipe[0] <= alu_res;
        itr_pipe[0]  <= i_itr;
        for (int s = 1; s < PE_LATENCY; s++) begin
            data_pipe[s] <= data_pipe[s-1];
            itr_pipe[s]  <= itr_pipe[s-1];
        end
    end

    assign o_bus = '{
        mask: mask_pipe[PE_LATENCY-1],
        itr:  itr_pipe[PE_LATENCY-1],
        data: data_pipe[PE_LATENCY-1]
    };

endmodule

// File: sdp_table_rf.sv
`timescale 1ns/1ps

module sdp_table_rf (
    input  logic                    clk,
    input  logic                    i_we,
    input  sdp_types_pkg::rf_addr_t i_waddr,
    input  sdp_types_pkg::phit_t    i_wdata,
    input  sdp_types_pkg::rf_addr_t i_raddr,
    output sdp_types_pkg::phit_t    o_rdata
);

    import sdp_types_pkg::*;

    phit_t mem [RF_DEPTH];

    // single write port, load or write-back chosen upstream
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // async read, sees a write right after its edge
    assign o_rdata = mem[i_raddr];

endmodule

// File: sdp_ctrl.sv
`timescale 1ns/1ps

module sdp_ctrl (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  logic                      i_cfg_we,
    input  sdp_cfg_pkg::stage_idx_t   i_cfg_stage,
    input  sdp_cfg_pkg::stage_cfg_t   i_cfg_word,
    input  logic                      i_itr_clr,
    input  sdp_types_pkg::lane_mask_t i_in_mask,
    input  logic                      i_tbl_we,
    input  sdp_cfg_pkg::stage_idx_t   i_tbl_stage,
    input  sdp_types_pkg::rf_addr_t   i_tbl_addr,
    input  sdp_types_pkg::phit_t      i_tbl_data,
    input  sdp_types_pkg::stage_bus_t i_stage_res [sdp_cfg_pkg::NUM_STAGES],
    output sdp_cfg_pkg::stage_cfg_t   o_cfg       [sdp_cfg_pkg::NUM_STAGES],
    output sdp_types_pkg::itr_t       o_itr,
    output logic [sdp_cfg_pkg::NUM_STAGES-1:0] o_rf_we,
    output sdp_types_pkg::rf_addr_t   o_rf_waddr  [sdp_cfg_pkg::NUM_STAGES],
    output sdp_types_pkg::phit_t      o_rf_wdata  [sdp_cfg_pkg::NUM_STAGES]
);

    import sdp_types_pkg::*;
    import sdp_cfg_pkg::*;

    stage_cfg_t cfg_q [NUM_STAGES];
    itr_t       itr_q;

    // per-stage config words, new word active next cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int s = 0; s < NUM_STAGES; s++) begin
                cfg_q[s] <= CFG_RESET;
            end
        end else if (i_cfg_we) begin
            for (int s = 0; s < NUM_STAGES; s++) begin
                if (i_cfg_stage == stage_idx_t'(s)) begin
                    cfg_q[s] <= i_cfg_word;
                end
            end
        end
    end

    // counts phits with any valid lane, clear has priority
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            itr_q <= '0;
        end else if (i_itr_clr) begin
            itr_q <= '0;
        end else if (|i_in_mask) begin
            itr_q <= itr_q + 1'b1;
        end
    end

    // the entering phit carries the pre-increment value
    assign o_itr = itr_q;

    for (genvar s = 0; s < NUM_STAGES; s++) begin : g_wport
        logic load_hit;
        logic wb_hit;

        assign load_hit = i_tbl_we && (i_tbl_stage == stage_idx_t'(s));
        assign wb_hit   = cfg_q[s].wb_en && (|i_stage_res[s].mask);

        // runtime load wins, a clashing write-back is lost
        assign o_rf_we[s]    = load_hit || wb_hit;
        assign o_rf_waddr[s] = load_hit ? i_tbl_addr : cfg_q[s].wb_addr;
        assign o_rf_wdata[s] = load_hit ? i_tbl_data : i_stage_res[s].data;

        assign o_cfg[s] = cfg_q[s];
    end

endmodule

// File: sdp_data_path.sv
`timescale 1ns/1ps

module sdp_data_path (
    input  logic                      clk,
    input  logic                      i_arst_n,
    input  sdp_types_pkg::phit_t      i_stream_in,
    input  sdp_types_pkg::lane_mask_t i_stream_valid,
    input  logic                      i_itr_clr,
    input  logic                      i_cfg_we,
    input  sdp_cfg_pkg::stage_idx_t   i_cfg_stage,
    input  sdp_cfg_pkg::stage_cfg_t   i_cfg_word,
    input  logic                      i_tbl_we,
    input  sdp_cfg_pkg::stage_idx_t   i_tbl_stage,
    input  sdp_types_pkg::rf_addr_t   i_tbl_addr,
    input  sdp_types_pkg::phit_t      i_tbl_data,
    output sdp_types_pkg::phit_t      o_stream_out,
    output sdp_types_pkg::lane_mask_t o_stream_valid
);

    import sdp_types_pkg::*;
    import sdp_cfg_pkg::*;

    // bus[k] enters stage k, bus[NUM_STAGES] is the output
    stage_bus_t            bus       [NUM_STAGES+1];
    stage_bus_t            stage_res [NUM_STAGES];
    stage_cfg_t            cfg       [NUM_STAGES];
    itr_t                  itr_cnt;
    logic [NUM_STAGES-1:0] rf_we;
    rf_addr_t              rf_waddr  [NUM_STAGES];
    phit_t                 rf_wdata  [NUM_STAGES];

    sdp_ctrl u_ctrl (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_stage (i_cfg_stage),
        .i_cfg_word  (i_cfg_word),
        .i_itr_clr   (i_itr_clr),
        .i_in_mask   (i_stream_valid),
        .i_tbl_we    (i_tbl_we),
        .i_tbl_stage (i_tbl_stage),
        .i_tbl_addr  (i_tbl_addr),
        .i_tbl_data  (i_tbl_data),
        .i_stage_res (stage_res),
        .o_cfg       (cfg),
        .o_itr       (itr_cnt),
        .o_rf_we     (rf_we),
        .o_rf_waddr  (rf_waddr),
        .o_rf_wdata  (rf_wdata)
    );

    assign bus[0] = '{mask: i_stream_valid, itr: itr_cnt, data: i_stream_in};

    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_stage
        rf_addr_t rf_raddr;
        phit_t    rf_rdata;
        phit_t    op_a;
        phit_t    op_b;

        sdp_operand_sel u_sel (
            .i_bus      (bus[k]),
            .i_cfg      (cfg[k]),
            .i_rf_rdata (rf_rdata),
            .o_rf_raddr (rf_raddr),
            .o_op_a     (op_a),
            .o_op_b     (op_b)
        );

        sdp_pe_stage u_pe (
            .clk      (clk),
            .i_arst_n (i_arst_n),
            .i_op     (cfg[k].op),
            .i_mask   (bus[k].mask),
            .i_itr    (bus[k].itr),
            .i_op_a   (op_a),
            .i_op_b   (op_b),
            .o_bus    (stage_res[k])
        );

        sdp_table_rf u_rf (
            .clk     (clk),
            .i_we    (rf_we[k]),
            .i_waddr (rf_waddr[k]),
            .i_wdata (rf_wdata[k]),
            .i_raddr (rf_raddr),
            .o_rdata (rf_rdata)
        );

        assign bus[k+1] = stage_res[k];
    end

    assign o_stream_out   = bus[NUM_STAGES].data;
    assign o_stream_valid = bus[NUM_STAGES].mask;

endmodule

// File: tb_sdp_data_path.sv
`timescale 1ns/1ps

module tb_sdp_data_path;

    import sdp_types_pkg::*;
    import sdp_cfg_pkg::*;

    // all tests together take about 200 cycles
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int LATENCY = NUM_STAGES * PE_LATENCY;
    localparam int unsigned LANE_MOD = 1 << DWIDTH;

    logic       clk;
    logic       arst_n;
    phit_t      stream_in;
    lane_mask_t stream_valid;
    logic       itr_clr;
    logic       cfg_we;
    stage_idx_t cfg_stage;
    stage_cfg_t cfg_word;
    logic       tbl_we;
    stage_idx_t tbl_stage;
    rf_addr_t   tbl_addr;
    phit_t      tbl_data;
    phit_t      stream_out;
    lane_mask_t stream_out_valid;

    logic [15:0] lfsr;
    int          cyc = 0;

    // reference model state
    stage_cfg_t m_cfg [NUM_STAGES];
    phit_t      m_tbl [NUM_STAGES][RF_DEPTH];
    itr_t       m_itr;
    stage_bus_t exp_q [$];
    int         due_q [$];

    sdp_data_path dut (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_stream_in    (stream_in),
        .i_stream_valid (stream_valid),
        .i_itr_clr      (itr_clr),
        .i_cfg_we       (cfg_we),
        .i_cfg_stage    (cfg_stage),
        .i_cfg_word     (cfg_word),
        .i_tbl_we       (tbl_we),
        .i_tbl_stage    (tbl_stage),
        .i_tbl_addr     (tbl_addr),
        .i_tbl_data     (tbl_data),
        .o_stream_out   (stream_out),
        .o_stream_valid (stream_out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (cyc == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "timeout");
        end else begin
            cyc <= cyc + 1;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic stage_cfg_t make_cfg(input pe_op_e op, input src_e a, input src_e b,
                                            input lane_t imm);
        stage_cfg_t c;
        c = '{op: op, src_a: a, src_b: b, imm: imm, rd_addr: '0,
              use_itr: 1'b0, wb_en: 1'b0, wb_addr: '0};
        return c;
    endfunction

    // unsigned lane arithmetic done wide, then folded back to the lane width
    function automatic lane_t ref_lane(input pe_op_e op, input lane_t a, input lane_t b);
        int unsigned ia;
        int unsigned ib;
        int unsigned r;
        ia = int'(a);
        ib = int'(b);
        case (op)
            OP_ADD:  r = (ia + ib) % LANE_MOD;
            OP_SUB:  r = (ia + LANE_MOD - ib) % LANE_MOD;
            OP_MAX:  r = (ia >= ib) ? ia : ib;
            default: r = (ia <= ib) ? ia : ib;
        endcase
        return lane_t'(r);
    endfunction

    function automatic phit_t ref_operand(input src_e src, input stage_bus_t b,
                                          input lane_t imm, input phit_t rf);
        phit_t v;
        for (int i = 0; i < SIMD_DEGREE; i++) begin
            case (src)
                SRC_STREAM: v[i*DWIDTH +: DWIDTH] = b.data[i*DWIDTH +: DWIDTH];
                SRC_ITR:    v[i*DWIDTH +: DWIDTH] = lane_t'(b.itr);
                SRC_IMM:    v[i*DWIDTH +: DWIDTH] = imm;
                default:    v[i*DWIDTH +: DWIDTH] = rf[i*DWIDTH +: DWIDTH];
            endcase
        end
        return v;
    endfunction

    // runs one phit through all stages, queues the expected output
    task automatic model_phit(input phit_t data, input lane_mask_t mask);
        stage_bus_t b;
        rf_addr_t   ra;
        phit_t      op_a;
        phit_t      op_b;
        if (mask != '0) begin
            b = '{mask: mask, itr: m_itr, data: data};
            m_itr = itr_t'(m_itr + 1);
            for (int k = 0; k < NUM_STAGES; k++) begin
                ra = m_cfg[k].use_itr ? rf_addr_t'(b.itr) : m_cfg[k].rd_addr;
                op_a = ref_operand(m_cfg[k].src_a, b, m_cfg[k].imm, m_tbl[k][ra]);
                op_b = ref_operand(m_cfg[k].src_b, b, m_cfg[k].imm, m_tbl[k][ra]);
                for (int i = 0; i < SIMD_DEGREE; i++) begin
                    b.data[i*DWIDTH +: DWIDTH] = ref_lane(m_cfg[k].op,
                        op_a[i*DWIDTH +: DWIDTH], op_b[i*DWIDTH +: DWIDTH]);
                end
                // spaced phits see this write
                if (m_cfg[k].wb_en) begin
                    m_tbl[k][m_cfg[k].wb_addr] = b.data;
                end
            end
            exp_q.push_back(b);
            due_q.push_back(cyc + LATENCY);
        end
    endtask

    task automatic check_mask(input lane_mask_t got, input lane_mask_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "mask mismatch");
        end
    endtask

    task automatic check_phit(input phit_t got, input phit_t exp, input lane_mask_t mask,
                              input string what);
        int bad;
        bad = -1;
        for (int i = 0; i < SIMD_DEGREE; i++) begin
            if (bad < 0 && mask[i] && got[i*DWIDTH +: DWIDTH] !== exp[i*DWIDTH +: DWIDTH]) begin
                bad = i;
            end
        end
        if (bad >= 0) begin
            $display("FAILED at %0t: %s lane %0d is %h, expected %h", $time, what, bad,
                     got[bad*DWIDTH +: DWIDTH], exp[bad*DWIDTH +: DWIDTH]);
            $display("Errors found");
            $fatal(1, "data mismatch");
        end
    endtask

    // every cycle either the next expected phit is due or the output is idle
    task automatic check_outputs();
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            check_mask(stream_out_valid, exp_q[0].mask, "output mask");
            check_phit(stream_out, exp_q[0].data, exp_q[0].mask, "output data");
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end else begin
            check_mask(stream_out_valid, '0, "idle output mask");
        end
    endtask

    task automatic idle_inputs();
        stream_in    = '0;
        stream_valid = '0;
        itr_clr      = 1'b0;
        cfg_we       = 1'b0;
        cfg_stage    = '0;
        cfg_word     = '0;
        tbl_we       = 1'b0;
        tbl_stage    = '0;
        tbl_addr     = '0;
        tbl_data     = '0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
        idle_inputs();
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic drain();
        while (due_q.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic send_phit(input phit_t data, input lane_mask_t mask);
        next_cycle();
        stream_in    = data;
        stream_valid = mask;
        model_phit(data, mask);
    endtask

    task automatic cfg_write(input int stage, input stage_cfg_t word);
        next_cycle();
        cfg_we    = 1'b1;
        cfg_stage = stage_idx_t'(stage);
        cfg_word  = word;
        m_cfg[stage] = word;
    endtask

    task automatic tbl_load(input int stage, input int addr, input phit_t data);
        next_cycle();
        tbl_we    = 1'b1;
        tbl_stage = stage_idx_t'(stage);
        tbl_addr  = rf_addr_t'(addr);
        tbl_data  = data;
        m_tbl[stage][addr] = data;
    endtask

    task automatic itr_clear();
        next_cycle();
        itr_clr = 1'b1;
        m_itr   = '0;
    endtask

    task automatic restore_cfg();
        for (int s = 0; s < NUM_STAGES; s++) begin
            cfg_write(s, make_cfg(OP_ADD, SRC_STREAM, SRC_IMM, '0));
        end
    endtask

    task automatic test_reset_passthrough();
        for (int n = 0; n < 12; n++) begin
            send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
        end
        drain();
    endtask

    task automatic test_imm_ops();
        cfg_write(0, make_cfg(OP_SUB, SRC_STREAM, SRC_IMM, 16'hc000));
        cfg_write(1, make_cfg(OP_MAX, SRC_STREAM, SRC_IMM, 16'h4000));
        cfg_write(2, make_cfg(OP_MIN, SRC_STREAM, SRC_IMM, 16'he000));
        // small lanes wrap on the subtract
        send_phit({16'hffff, 16'h0000, 16'h0001, 16'h0005}, '1);
        for (int n = 0; n < 10; n++) begin
            send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
        end
        drain();
        cfg_write(0, make_cfg(OP_ADD, SRC_STREAM, SRC_IMM, 16'h8001));
        cfg_write(1, make_cfg(OP_MIN, SRC_STREAM, SRC_IMM, 16'h7fff));
        cfg_write(2, make_cfg(OP_SUB, SRC_IMM, SRC_STREAM, 16'h0010));
        for (int n = 0; n < 8; n++) begin
            send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
        end
        drain();
        restore_cfg();
    endtask

    task automatic test_itr_lookup();
        stage_cfg_t c;
        for (int a = 0; a < RF_DEPTH; a++) begin
            tbl_load(1, a, phit_t'(take_bits(PHIT_SIZE)));
        end
        c = make_cfg(OP_ADD, SRC_STREAM, SRC_RF, '0);
        c.use_itr = 1'b1;
        cfg_write(1, c);
        cfg_write(2, make_cfg(OP_ADD, SRC_STREAM, SRC_ITR, '0));
        itr_clear();
        for (int n = 0; n < 10; n++) begin
            send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
        end
        drain();
        restore_cfg();
    endtask

    task automatic test_wb_accum();
        stage_cfg_t c;
        tbl_load(0, 3, '0);
        c = make_cfg(OP_ADD, SRC_STREAM, SRC_RF, '0);
        c.rd_addr = 3'd3;
        c.wb_en   = 1'b1;
        c.wb_addr = 3'd3;
        cfg_write(0, c);
        for (int n = 0; n < 5; n++) begin
            send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
            idle(PE_LATENCY);
        end
        // load lands on the same edge as this phit's write-back
        send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
        idle(PE_LATENCY - 1);
        tbl_load(0, 3, {SIMD_DEGREE{16'h0100}});
        for (int n = 0; n < 4; n++) begin
            send_phit(phit_t'(take_bits(PHIT_SIZE)), '1);
            idle(PE_LATENCY);
        end
        drain();
        restore_cfg();
    endtask

    task automatic test_stream_masks();
        lane_mask_t m;
        cfg_write(0, make_cfg(OP_ADD, SRC_STREAM, SRC_ITR, '0));
        cfg_write(1, make_cfg(OP_SUB, SRC_STREAM, SRC_IMM, 16'h0101));
        itr_clear();
        for (int n = 0; n < 40; n++) begin
            if (n % 5 == 4) begin
                m = '0;
            end else begin
                m = lane_mask_t'(take_bits(SIMD_DEGREE));
            end
            send_phit(phit_t'(take_bits(PHIT_SIZE)), m);
        end
        drain();
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        lfsr   = 16'd38;
        arst_n = 1'b0;
        idle_inputs();
        m_itr = '0;
        for (int s = 0; s < NUM_STAGES; s++) begin
            m_cfg[s] = make_cfg(OP_ADD, SRC_STREAM, SRC_IMM, '0);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset_passthrough();
        test_imm_ops();
        test_itr_lookup();
        test_wb_accum();
        test_stream_masks();
        $display("No errors");
        $finish;
    end

endmodule

// File: sdp_data_path.f
sdp_types_pkg.sv
sdp_cfg_pkg.sv
sdp_operand_sel.sv
sdp_pe_stage.sv
sdp_table_rf.sv
sdp_ctrl.sv
sdp_data_path.sv
tb_sdp_data_path.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sdp_data_path testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_sdp_data_path

verilator --binary -Wno-fatal --top-module "$top" -f sdp_data_path.f -o "V$top"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

"./obj_dir/V$top"
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation passed"
exit 0
